//--- Makefile
# Verilator flow for the exception unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_exc_unit
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
src/exc_pkg.sv
src/exc_irq_sync.sv
src/exc_cause_decode.sv
src/exc_fsm.sv
src/exc_unit_top.sv
verification/tb_exc_unit.sv

//--- src/exc_cause_decode.sv
// purely combinational; at most one cause is high, and nothing nests while a handler runs
`timescale 1ns/1ps
`default_nettype none

module exc_cause_decode import exc_pkg::*;
(
  input  wire logic illegal_insn_i,      // illegal instruction in id
  input  wire logic pipe_flush_i,        // flush request from the controller
  input  wire logic clear_isr_running_i, // return from exception in id
  input  wire logic fetch_enable_i,      // core should keep fetching
  input  wire logic irq_present_i,       // synchronized, enabled irq
  input  wire logic exc_running_i,       // a handler is active
  input  wire dsr_t dbg_dsr_i,           // debug stop bits
  output      logic cause_illegal_o,
  output      logic cause_irq_o,
  output      logic cause_flush_o
);

  ////////////////////
  // priority decode
  ////////////////////

  always_comb
  begin
    cause_illegal_o = 1'b0;
    cause_irq_o     = 1'b0;
    cause_flush_o   = 1'b0;

    if (illegal_insn_i)
    begin
      // debug takes it when IIE is set, and a running handler masks it;
      // in both cases lower causes stay masked too
      if (!dbg_dsr_i[DSR_IIE] && !exc_running_i)
        cause_illegal_o = 1'b1;
    end
    else if (irq_present_i && !exc_running_i)
    begin
      // INTE hands the irq to the debug unit instead
      if (!dbg_dsr_i[DSR_INTE])
        cause_irq_o = 1'b1;
    end
    else if (pipe_flush_i)
    begin
      cause_flush_o = 1'b1; // sync style flush, no handler
    end
    else if (clear_isr_running_i)
    begin
      if (exc_running_i)
      begin
        // leaving the handler; drain and stop if the core goes to sleep
        if (!fetch_enable_i)
          cause_flush_o = 1'b1;
      end
      else
      begin
        cause_illegal_o = 1'b1; // rfe outside a handler is illegal
      end
    end
  end

endmodule

`default_nettype wire

//--- src/exc_fsm.sv
// state advances only on cycles with no stall and no drop; drop also forces idle outputs
`timescale 1ns/1ps
`default_nettype none

module exc_fsm import exc_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        stall_id_i,          // freezes all state
  input  wire logic        drop_instruction_i,  // mispredict, freezes state and idles outputs
  input  wire logic        core_busy_i,
  input  wire logic        illegal_insn_i,      // raw illegal flag, only for the debug trap
  input  wire logic        trap_insn_i,
  input  wire logic        dbg_flush_pipe_i,
  input  wire logic        dbg_st_en_i,         // single step
  input  wire logic        clear_isr_running_i, // rfe
  input  wire logic        irq_present_i,
  input  wire logic        cause_illegal_i,
  input  wire logic        cause_irq_i,
  input  wire logic        cause_flush_i,
  input  wire jump_t       jump_in_id_i,
  input  wire dsr_t        dbg_dsr_i,
  input  wire exc_pc_mux_t irq_vec_i,
  output      logic        exc_running_o,
  output      logic        exc_pc_sel_o,        // fetch takes exc_pc_mux_o
  output      logic        force_nop_o,         // bubble into id
  output      logic        pc_valid_o,
  output      logic        save_pc_if_o,
  output      logic        save_pc_id_o,
  output      logic        save_sr_o,
  output      logic        pipe_flushed_o,
  output      logic        hwloop_enable_o,
  output      logic        trap_hit_o,
  output      exc_pc_mux_t exc_pc_mux_o
);

  exc_state_e  state_q, state_d;
  exc_reason_e reason_q, reason_d;
  exc_reason_e reason_new;             // cause of this cycle, as a reason code
  logic        running_q, running_d;
  logic        clear_reason;
  logic        delay_slot;
  logic        advance;

  assign delay_slot = |jump_in_id_i;   // any jump kind leaves a delay slot
  assign advance    = !stall_id_i && !drop_instruction_i;

  // causes arrive one-hot or zero
  assign reason_new = cause_illegal_i ? ExcIllegal :
                      cause_irq_i     ? ExcIrq     :
                      cause_flush_i   ? ExcFlush   : ExcNone;

  ////////////////////
  // next state and outputs
  ////////////////////

  always_comb
  begin
    state_d        = state_q;
    reason_d       = reason_q;
    running_d      = running_q;
    clear_reason   = 1'b0;
    force_nop_o    = 1'b0;
    exc_pc_sel_o   = 1'b0;
    exc_pc_mux_o   = EXC_PC_NO_INCR;
    pc_valid_o     = 1'b1;
    save_pc_if_o   = 1'b0;
    save_pc_id_o   = 1'b0;
    save_sr_o      = 1'b0;
    pipe_flushed_o = 1'b0;

    if (!drop_instruction_i)
    begin
      case (state_q)
        Idle:
        begin
          reason_d = reason_new;
          case (reason_new)
            ExcFlush:
            begin
              if (delay_slot)
              begin
                state_d = NopDelay;      // let the slot retire first
              end
              else
              begin
                force_nop_o  = 1'b1;
                exc_pc_sel_o = 1'b1;     // hold pc
                pc_valid_o   = 1'b0;
                state_d      = NopId;
              end
            end
            ExcIrq:
            begin
              if (delay_slot)
              begin
                state_d = NopDelayIr;
              end
              else
              begin
                force_nop_o  = 1'b1;
                exc_pc_sel_o = 1'b1;
                exc_pc_mux_o = irq_vec_i;
                save_pc_if_o = 1'b1;     // resume at the fetched pc
                save_sr_o    = 1'b1;
                running_d    = 1'b1;
                clear_reason = 1'b1;
              end
            end
            ExcIllegal:
            begin
              // no drain needed, the faulting insn is squashed
              force_nop_o  = 1'b1;
              exc_pc_sel_o = 1'b1;
              exc_pc_mux_o = EXC_PC_ILLINSN;
              save_pc_id_o = 1'b1;       // pc of the faulting insn
              save_sr_o    = 1'b1;
              running_d    = 1'b1;
              clear_reason = 1'b1;
            end
            default:
            begin
              state_d = Idle;            // nothing pending
            end
          endcase
        end

        NopDelayIr:
        begin
          force_nop_o  = 1'b1;           // slot has gone, now jump
          exc_pc_sel_o = 1'b1;
          exc_pc_mux_o = irq_vec_i;
          save_pc_if_o = 1'b1;
          save_sr_o    = 1'b1;
          running_d    = 1'b1;
          clear_reason = 1'b1;
          state_d      = Idle;
        end

        NopDelay, NopId, NopEx:
        begin
          force_nop_o  = 1'b1;           // bubbles march down the pipe
          exc_pc_sel_o = 1'b1;
          pc_valid_o   = 1'b0;
          state_d      = (state_q == NopDelay) ? NopId :
                         (state_q == NopId)    ? NopEx : NopWb;
        end

        NopWb:
        begin
          force_nop_o    = 1'b1;
          exc_pc_sel_o   = 1'b1;
          pc_valid_o     = 1'b0;
          pipe_flushed_o = (reason_q == ExcFlush); // first bubble reached wb
          clear_reason   = 1'b1;
          state_d        = Idle;
        end

        default:
        begin
          state_d = Idle;
        end
      endcase
    end
  end

  ////////////////////
  // state registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= Idle;
      reason_q  <= ExcNone;
      running_q <= 1'b0;
    end
    else if (advance)
    begin
      state_q   <= state_d;
      reason_q  <= clear_reason ? ExcNone : reason_d;
      running_q <= clear_isr_running_i ? 1'b0 : running_d; // rfe ends the handler
    end
  end

  assign exc_running_o = running_q;

  // hw loops keep going unless bubbles are inserted into a busy core
  assign hwloop_enable_o = !force_nop_o || !core_busy_i;

  // debug traps: software trap, halt, step, or a cause that debug claims
  assign trap_hit_o = trap_insn_i || dbg_flush_pipe_i || dbg_st_en_i
                   || (illegal_insn_i && dbg_dsr_i[DSR_IIE])
                   || (irq_present_i && dbg_dsr_i[DSR_INTE] && !running_q);

endmodule

`default_nettype wire

//--- src/exc_irq_sync.sv
// irq lines are async levels held until serviced; presence shows up 2 clk cycles after the line
`timescale 1ns/1ps
`default_nettype none

module exc_irq_sync import exc_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        irq_i,         // maskable line, async level
  input  wire logic        irq_nm_i,      // non-maskable line, async level
  input  wire logic        irq_enable_i,  // global enable from the status register
  output      logic        irq_present_o, // some enabled irq is pending
  output      exc_pc_mux_t irq_vec_o      // vector to take when the irq is serviced
);

  ////////////////////
  // synchronizers
  ////////////////////

  logic [1:0] irq_sync_q;    // [0] first stage, [1] second stage
  logic [1:0] irq_nm_sync_q; // same layout for the nm line

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_sync_q    <= 2'b00;
      irq_nm_sync_q <= 2'b00;
    end
    else
    begin
      irq_sync_q    <= {irq_sync_q[0], irq_i};       // shift in
      irq_nm_sync_q <= {irq_nm_sync_q[0], irq_nm_i};
    end
  end

  ////////////////////
  // gating and vector
  ////////////////////

  // enable masks both lines, as the status register covers the nm line too
  assign irq_present_o = (irq_sync_q[1] | irq_nm_sync_q[1]) & irq_enable_i;

  // nm line wins whenever both are up
  assign irq_vec_o = irq_nm_sync_q[1] ? EXC_PC_IRQ_NM : EXC_PC_IRQ;

endmodule

`default_nettype wire

//--- src/exc_pkg.sv
// shared vector codes, debug stop bits and state types; vector addresses live in the fetch stage
`default_nettype none

package exc_pkg;

  ////////////////////
  // width typedefs
  ////////////////////

  typedef logic [1:0] exc_pc_mux_t; // fetch vector selector
  typedef logic [1:0] dsr_t;        // debug stop register slice
  typedef logic [1:0] jump_t;       // jump kind in id, nonzero means delay slot pending

  // vector selector codes seen by the fetch stage
  localparam exc_pc_mux_t EXC_PC_NO_INCR = 2'd0; // hold the pc
  localparam exc_pc_mux_t EXC_PC_ILLINSN = 2'd1; // illegal instruction vector
  localparam exc_pc_mux_t EXC_PC_IRQ     = 2'd2; // maskable interrupt vector
  localparam exc_pc_mux_t EXC_PC_IRQ_NM  = 2'd3; // non-maskable interrupt vector

  // bit positions inside dsr_t
  localparam int unsigned DSR_IIE  = 0; // illegal instruction goes to debug
  localparam int unsigned DSR_INTE = 1; // interrupt goes to debug

  ////////////////////
  // state types
  ////////////////////

  typedef enum logic [2:0] {
    Idle,
    NopDelay,   // delay slot executes before the flush bubbles
    NopDelayIr, // delay slot executes before the irq jump
    NopId,
    NopEx,
    NopWb
  } exc_state_e;

  typedef enum logic [1:0] {
    ExcNone,
    ExcIrq,
    ExcFlush,
    ExcIllegal
  } exc_reason_e;

endpackage

`default_nettype wire

//--- src/exc_unit_top.sv
// vector addresses and the spr file are outside; interrupts add 2 cycles to the fsm latency
`timescale 1ns/1ps
`default_nettype none

module exc_unit_top import exc_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        irq_i,
  input  wire logic        irq_nm_i,
  input  wire logic        irq_enable_i,
  input  wire logic        illegal_insn_i,
  input  wire logic        pipe_flush_i,
  input  wire logic        clear_isr_running_i,
  input  wire logic        fetch_enable_i,
  input  wire dsr_t        dbg_dsr_i,
  input  wire logic        stall_id_i,
  input  wire logic        drop_instruction_i,
  input  wire logic        core_busy_i,
  input  wire logic        trap_insn_i,
  input  wire logic        dbg_flush_pipe_i,
  input  wire logic        dbg_st_en_i,
  input  wire jump_t       jump_in_id_i,
  output      logic        irq_present_o,
  output      logic        exc_running_o,
  output      logic        exc_pc_sel_o,
  output      logic        force_nop_o,
  output      logic        pc_valid_o,
  output      logic        save_pc_if_o,
  output      logic        save_pc_id_o,
  output      logic        save_sr_o,
  output      logic        pipe_flushed_o,
  output      logic        hwloop_enable_o,
  output      logic        trap_hit_o,
  output      exc_pc_mux_t exc_pc_mux_o
);

  exc_pc_mux_t irq_vec;
  logic        cause_illegal, cause_irq, cause_flush;

  exc_irq_sync u_irq_sync (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_i         (irq_i),
    .irq_nm_i      (irq_nm_i),
    .irq_enable_i  (irq_enable_i),
    .irq_present_o (irq_present_o),
    .irq_vec_o     (irq_vec)
  );

  exc_cause_decode u_cause_decode (
    .illegal_insn_i      (illegal_insn_i),
    .pipe_flush_i        (pipe_flush_i),
    .clear_isr_running_i (clear_isr_running_i),
    .fetch_enable_i      (fetch_enable_i),
    .irq_present_i       (irq_present_o),
    .exc_running_i       (exc_running_o),   // fed back from the fsm
    .dbg_dsr_i           (dbg_dsr_i),
    .cause_illegal_o     (cause_illegal),
    .cause_irq_o         (cause_irq),
    .cause_flush_o       (cause_flush)
  );

  exc_fsm u_fsm (
    .clk                 (clk),
    .rst_n               (rst_n),
    .stall_id_i          (stall_id_i),
    .drop_instruction_i  (drop_instruction_i),
    .core_busy_i         (core_busy_i),
    .illegal_insn_i      (illegal_insn_i),
    .trap_insn_i         (trap_insn_i),
    .dbg_flush_pipe_i    (dbg_flush_pipe_i),
    .dbg_st_en_i         (dbg_st_en_i),
    .clear_isr_running_i (clear_isr_running_i),
    .irq_present_i       (irq_present_o),
    .cause_illegal_i     (cause_illegal),
    .cause_irq_i         (cause_irq),
    .cause_flush_i       (cause_flush),
    .jump_in_id_i        (jump_in_id_i),
    .dbg_dsr_i           (dbg_dsr_i),
    .irq_vec_i           (irq_vec),
    .exc_running_o       (exc_running_o),
    .exc_pc_sel_o        (exc_pc_sel_o),
    .force_nop_o         (force_nop_o),
    .pc_valid_o          (pc_valid_o),
    .save_pc_if_o        (save_pc_if_o),
    .save_pc_id_o        (save_pc_id_o),
    .save_sr_o           (save_sr_o),
    .pipe_flushed_o      (pipe_flushed_o),
    .hwloop_enable_o     (hwloop_enable_o),
    .trap_hit_o          (trap_hit_o),
    .exc_pc_mux_o        (exc_pc_mux_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_exc_unit.sv
// inputs change 1 ns after clk rises; the model assumes stall and drop freeze every fsm register
`timescale 1ns/1ps
`default_nettype none

module tb_exc_unit
  import exc_pkg::*;
();

  localparam int          HALF_PERIOD   = 4;    // 8 ns clock
  localparam int          RANDOM_CYCLES = 4000;
  localparam int          WAIT_LIMIT    = 16;   // longest any single wait may take
  localparam logic [31:0] SEED          = 32'h7d78ef38;

  ////////////////////
  // dut signals
  ////////////////////

  logic        clk;
  logic        rst_n;
  logic        irq_i, irq_nm_i, irq_enable_i;
  logic        illegal_insn_i, pipe_flush_i, clear_isr_running_i, fetch_enable_i;
  dsr_t        dbg_dsr_i;
  logic        stall_id_i, drop_instruction_i, core_busy_i;
  logic        trap_insn_i, dbg_flush_pipe_i, dbg_st_en_i;
  jump_t       jump_in_id_i;
  logic        irq_present_o, exc_running_o, exc_pc_sel_o, force_nop_o, pc_valid_o;
  logic        save_pc_if_o, save_pc_id_o, save_sr_o, pipe_flushed_o;
  logic        hwloop_enable_o, trap_hit_o;
  exc_pc_mux_t exc_pc_mux_o;

  // model state and expected outputs
  logic [1:0]  m_irq_sync, m_nm_sync;     // [1] is the stage the dut looks at
  exc_state_e  m_state, m_state_nxt;
  logic        m_running, m_running_nxt;
  logic        m_irq_present, c_ill, c_irq, c_fl;
  logic        jump, bubble, flushed;
  exc_pc_mux_t m_vec, jump_vec;
  logic        exp_hwloop, exp_trap;

  logic [31:0] rng_state;
  int          checks     = 0;
  int          mismatches = 0;
  int          timeouts   = 0;

  exc_unit_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // true about once in n calls, low bits of an lcg are weak so skip them
  function automatic logic chance(input int unsigned n);
    logic [31:0] v;
    v = lcg_next();
    return ((v >> 12) % n) == 0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                     // drive point
  endtask

  task automatic drive_defaults();
    irq_i               = 1'b0;
    irq_nm_i            = 1'b0;
    irq_enable_i        = 1'b1;
    illegal_insn_i      = 1'b0;
    pipe_flush_i        = 1'b0;
    clear_isr_running_i = 1'b0;
    fetch_enable_i      = 1'b1;
    dbg_dsr_i           = '0;
    jump_in_id_i        = '0;
    stall_id_i          = 1'b0;
    drop_instruction_i  = 1'b0;
    core_busy_i         = 1'b0;
    trap_insn_i         = 1'b0;
    dbg_flush_pipe_i    = 1'b0;
    dbg_st_en_i         = 1'b0;
  endtask

  task automatic randomize_inputs();
    logic [31:0] v;
    if (chance(24)) irq_i = ~irq_i;         // lines are levels, toggle rarely
    if (chance(40)) irq_nm_i = ~irq_nm_i;
    irq_enable_i        = !chance(8);
    illegal_insn_i      = chance(24);
    pipe_flush_i        = chance(24);
    clear_isr_running_i = chance(10);
    fetch_enable_i      = !chance(6);
    dbg_dsr_i[DSR_IIE]  = chance(8);
    dbg_dsr_i[DSR_INTE] = chance(8);
    stall_id_i          = chance(6);
    drop_instruction_i  = chance(12);
    core_busy_i         = chance(2);
    trap_insn_i         = chance(32);
    dbg_flush_pipe_i    = chance(64);
    dbg_st_en_i         = chance(64);
    v = lcg_next();
    jump_in_id_i = (v[31:30] == 2'b00) ? v[17:16] : 2'b00; // mostly no delay slot
  endtask

  ////////////////////
  // cycle model
  ////////////////////

  always_comb
  begin
    m_irq_present = (m_irq_sync[1] | m_nm_sync[1]) & irq_enable_i;
    m_vec         = m_nm_sync[1] ? EXC_PC_IRQ_NM : EXC_PC_IRQ;
    // decode rules in priority order
    c_ill = 1'b0;
    c_irq = 1'b0;
    c_fl  = 1'b0;
    if (illegal_insn_i)
      c_ill = !dbg_dsr_i[DSR_IIE] && !m_running;
    else if (m_irq_present && !m_running)
      c_irq = !dbg_dsr_i[DSR_INTE];
    else if (pipe_flush_i)
      c_fl = 1'b1;
    else if (clear_isr_running_i)
    begin
      if (m_running)
        c_fl = !fetch_enable_i;             // rfe into sleep drains
      else
        c_ill = 1'b1;                       // rfe with no handler
    end
    jump       = 1'b0;
    bubble     = 1'b0;
    flushed    = 1'b0;
    jump_vec   = EXC_PC_NO_INCR;
    m_state_nxt = m_state;
    case (m_state)
      Idle:
      begin
        if (c_ill)
        begin
          jump     = 1'b1;
          jump_vec = EXC_PC_ILLINSN;
        end
        else if (c_irq && |jump_in_id_i)
          m_state_nxt = NopDelayIr;         // slot first, jump later
        else if (c_irq)
        begin
          jump     = 1'b1;
          jump_vec = m_vec;
        end
        else if (c_fl && |jump_in_id_i)
          m_state_nxt = NopDelay;
        else if (c_fl)
        begin
          bubble      = 1'b1;
          m_state_nxt = NopId;
        end
      end
      NopDelayIr:
      begin
        jump        = 1'b1;
        jump_vec    = m_vec;
        m_state_nxt = Idle;
      end
      NopDelay:
      begin
        bubble      = 1'b1;
        m_state_nxt = NopId;
      end
      NopId:
      begin
        bubble      = 1'b1;
        m_state_nxt = NopEx;
      end
      NopEx:
      begin
        bubble      = 1'b1;
        m_state_nxt = NopWb;
      end
      NopWb:
      begin
        bubble      = 1'b1;
        flushed     = 1'b1;                 // one pulse as the last bubble lands
        m_state_nxt = Idle;
      end
      default: m_state_nxt = Idle;
    endcase
    if (drop_instruction_i)
    begin
      jump     = 1'b0;                      // drop shows idle outputs
      bubble   = 1'b0;
      flushed  = 1'b0;
      jump_vec = EXC_PC_NO_INCR;
    end
    m_running_nxt = m_running | jump;
    exp_hwloop    = !(jump | bubble) || !core_busy_i;
    exp_trap      = trap_insn_i || dbg_flush_pipe_i || dbg_st_en_i
                 || (illegal_insn_i && dbg_dsr_i[DSR_IIE])
                 || (m_irq_present && dbg_dsr_i[DSR_INTE] && !m_running);
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_irq_sync <= 2'b00;
      m_nm_sync  <= 2'b00;
      m_state    <= Idle;
      m_running  <= 1'b0;
    end
    else
    begin
      m_irq_sync <= {m_irq_sync[0], irq_i};
      m_nm_sync  <= {m_nm_sync[0], irq_nm_i};
      if (!stall_id_i && !drop_instruction_i)
      begin
        m_state   <= m_state_nxt;
        m_running <= clear_isr_running_i ? 1'b0 : m_running_nxt;
      end
    end
  end

  // every output, every cycle, mid cycle where all levels have settled
  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      check_value("irq_present_o", 32'(irq_present_o), 32'(m_irq_present));
      check_value("exc_running_o", 32'(exc_running_o), 32'(m_running));
      check_value("exc_pc_sel_o", 32'(exc_pc_sel_o), 32'(jump | bubble));
      check_value("force_nop_o", 32'(force_nop_o), 32'(jump | bubble));
      check_value("pc_valid_o", 32'(pc_valid_o), 32'(!bubble));
      check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(jump_vec));
      check_value("save_pc_if_o", 32'(save_pc_if_o), 32'(jump && jump_vec != EXC_PC_ILLINSN));
      check_value("save_pc_id_o", 32'(save_pc_id_o), 32'(jump && jump_vec == EXC_PC_ILLINSN));
      check_value("save_sr_o", 32'(save_sr_o), 32'(jump));
      check_value("pipe_flushed_o", 32'(pipe_flushed_o), 32'(flushed));
      check_value("hwloop_enable_o", 32'(hwloop_enable_o), 32'(exp_hwloop));
      check_value("trap_hit_o", 32'(trap_hit_o), 32'(exp_trap));
    end
  end

  ////////////////////
  // directed sequences
  ////////////////////

  task automatic wait_reset_release();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
      seen = (rst_n === 1'b1) && (pc_valid_o === 1'b1);
    end
    if (!seen)
    begin
      timeouts++;
      $display("reset release never brought pc_valid_o high");
    end
    else
    begin
      check_value("exc_pc_sel_o", 32'(exc_pc_sel_o), 32'(0)); // all idle after reset
      check_value("force_nop_o", 32'(force_nop_o), 32'(0));
      check_value("exc_running_o", 32'(exc_running_o), 32'(0));
      check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(EXC_PC_NO_INCR));
      check_value("save_pc_if_o", 32'(save_pc_if_o), 32'(0));
      check_value("save_pc_id_o", 32'(save_pc_id_o), 32'(0));
      check_value("save_sr_o", 32'(save_sr_o), 32'(0));
      check_value("pipe_flushed_o", 32'(pipe_flushed_o), 32'(0));
      check_value("trap_hit_o", 32'(trap_hit_o), 32'(0));
    end
  endtask

  // leaves the handler only if one is running, else rfe would be illegal
  task automatic leave_handler();
    next_cycle();
    clear_isr_running_i = m_running;
    next_cycle();
    clear_isr_running_i = 1'b0;
  endtask

  task automatic irq_latency_test();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    next_cycle();
    drive_defaults();
    irq_nm_i = 1'b1;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
      seen = irq_present_o;
    end
    if (!seen)
    begin
      timeouts++;
      $display("interrupt line never reached irq_present_o");
    end
    else
    begin
      check_value("irq_latency", n, 2);
      check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(EXC_PC_IRQ_NM));
      check_value("save_pc_if_o", 32'(save_pc_if_o), 32'(1));
      check_value("save_sr_o", 32'(save_sr_o), 32'(1));
    end
    next_cycle();
    irq_nm_i = 1'b0;
    repeat (4) next_cycle();                // let the synchronizers empty
    leave_handler();
  endtask

  task automatic illegal_test();
    next_cycle();
    drive_defaults();
    illegal_insn_i = 1'b1;
    @(negedge clk);
    check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(EXC_PC_ILLINSN));
    check_value("save_pc_id_o", 32'(save_pc_id_o), 32'(1));
    next_cycle();                           // handler running, same insn again
    @(negedge clk);
    check_value("exc_pc_sel_o", 32'(exc_pc_sel_o), 32'(0));
    next_cycle();
    illegal_insn_i      = 1'b0;
    clear_isr_running_i = 1'b1;
    next_cycle();
    clear_isr_running_i = 1'b0;
    dbg_dsr_i[DSR_IIE]  = 1'b1;             // debug claims it now
    illegal_insn_i      = 1'b1;
    @(negedge clk);
    check_value("trap_hit_o", 32'(trap_hit_o), 32'(1));
    check_value("exc_pc_sel_o", 32'(exc_pc_sel_o), 32'(0));
    next_cycle();
    drive_defaults();
  endtask

  task automatic flush_test(input jump_t kind, input int stall_cycles, input int want_cycles);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    next_cycle();
    drive_defaults();
    pipe_flush_i = 1'b1;
    jump_in_id_i = kind;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
      #1;
      pipe_flush_i = 1'b0;
      jump_in_id_i = '0;
      stall_id_i   = (n <= stall_cycles); // stalls hold the current bubble
      @(negedge clk);
      check_value("pc_valid_o", 32'(pc_valid_o), 32'(0));
      seen = pipe_flushed_o;
    end
    if (!seen)
    begin
      timeouts++;
      $display("flush request never produced a pipe_flushed_o pulse");
    end
    else
      check_value("flush_latency", n, want_cycles);
    next_cycle();
    drive_defaults();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    rng_state = SEED;
    rst_n     = 1'b0;
    drive_defaults();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    wait_reset_release();
    irq_latency_test();
    illegal_test();
    flush_test(2'd0, 0, 3);
    flush_test(2'd1, 0, 4);                 // delay slot adds NopDelay
    flush_test(2'd0, 2, 5);
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      next_cycle();
      randomize_inputs();
    end
    next_cycle();
    drive_defaults();
    next_cycle();
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
